// ==== hdl/sdram_pkg.sv ====
package sdram_pkg;

	localparam int BA_W  = 2;
	localparam int ROW_W = 12;
	localparam int COL_W = 8;
	localparam int DQ_W  = 16;

	typedef logic [DQ_W-1:0]             word_t;
	typedef logic [BA_W+ROW_W+COL_W-1:0] user_addr_t;   // bank, row, column from the top

	// {cs_n, ras_n, cas_n, we_n}
	localparam logic [3:0] CMD_NOP       = 4'b0111;
	localparam logic [3:0] CMD_ACTIVE    = 4'b0011;
	localparam logic [3:0] CMD_READ      = 4'b0101;
	localparam logic [3:0] CMD_WRITE     = 4'b0100;
	localparam logic [3:0] CMD_PRECHARGE = 4'b0010;
	localparam logic [3:0] CMD_REFRESH   = 4'b0001;
	localparam logic [3:0] CMD_LOAD_MODE = 4'b0000;

	localparam int T_RCD = 2;
	localparam int T_RP  = 2;
	localparam int T_RFC = 7;
	localparam int T_WR  = 2;
	localparam int T_MRD = 2;

	typedef union packed {
		logic [ROW_W-1:0] row;              // ACTIVE
		struct packed {
			logic             rsvd;
			logic             ap;           // auto-precharge, all banks on PRECHARGE
			logic [1:0]       unused;
			logic [COL_W-1:0] col;
		} cas;                              // READ and WRITE
		struct packed {
			logic [1:0] rsvd;
			logic       wb_mode;            // 0 = burst writes
			logic [1:0] op_mode;
			logic [2:0] cas_lat;
			logic       burst_type;         // 0 = sequential
			logic [2:0] burst_len;
		} mode;                             // LOAD_MODE
	} sdram_a_u;

endpackage

// ==== hdl/sdram_init.sv ====
`timescale 1ns/1ps

module sdram_init #(
	parameter int CAS_LAT          = 3,
	parameter int BURST_LEN        = 4,
	parameter int INIT_WAIT_CYCLES = 10000
) (
	input  logic                S_CLK,
	input  logic                RST_N,
	output logic [3:0]          init_cmd,
	output sdram_pkg::sdram_a_u init_a,
	output logic                init_done
);
	import sdram_pkg::*;

	// command slots counted from the end of the power-up wait
	localparam int P_AT    = 0;
	localparam int R1_AT   = P_AT + T_RP;
	localparam int R2_AT   = R1_AT + T_RFC;
	localparam int M_AT    = R2_AT + T_RFC;
	localparam int DONE_AT = M_AT + T_MRD;
	localparam int SEQ_W   = $clog2(DONE_AT + 1);
	localparam int WAIT_W  = $clog2(INIT_WAIT_CYCLES + 1);

	logic [WAIT_W-1:0] wait_cnt;
	logic              wait_done;
	logic [SEQ_W-1:0]  seq_cnt;
	sdram_a_u          mode_word;

	always_comb begin
		mode_word = '0;                                 // sequential, burst writes
		mode_word.mode.cas_lat   = 3'(CAS_LAT);
		mode_word.mode.burst_len = 3'($clog2(BURST_LEN)); // 1,2,4,8 -> 0..3
	end

	always_ff @(posedge S_CLK or negedge RST_N) begin
		if (!RST_N) begin
			wait_cnt  <= '0;
			wait_done <= 1'b0;
			seq_cnt   <= '0;
			init_cmd  <= CMD_NOP;
			init_a    <= '0;
			init_done <= 1'b0;
		end else begin
			init_cmd <= CMD_NOP;
			init_a   <= '0;
			if (!wait_done) begin
				if (wait_cnt == WAIT_W'(INIT_WAIT_CYCLES - 1))
					wait_done <= 1'b1;
				else
					wait_cnt <= wait_cnt + 1'b1;
			end else if (!init_done) begin
				seq_cnt <= seq_cnt + 1'b1;
				case (seq_cnt)
					SEQ_W'(P_AT): begin
						init_cmd      <= CMD_PRECHARGE;
						init_a.cas.ap <= 1'b1;              // all banks
					end
					SEQ_W'(R1_AT), SEQ_W'(R2_AT): init_cmd <= CMD_REFRESH;
					SEQ_W'(M_AT): begin
						init_cmd <= CMD_LOAD_MODE;
						init_a   <= mode_word;
					end
					SEQ_W'(DONE_AT): init_done <= 1'b1;
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== hdl/sdram_refresh_timer.sv ====
`timescale 1ns/1ps

module sdram_refresh_timer #(
	parameter int REFRESH_CYCLES = 780
) (
	input  logic S_CLK,
	input  logic RST_N,
	input  logic init_done,
	input  logic ref_ack,
	output logic ref_req
);

	localparam int CNT_W = $clog2(REFRESH_CYCLES + 1);

	logic [CNT_W-1:0] ref_cnt;

	// interval restarts on service, not on request
	always_ff @(posedge S_CLK or negedge RST_N) begin
		if (!RST_N) begin
			ref_cnt <= '0;
			ref_req <= 1'b0;
		end else if (ref_ack) begin
			ref_cnt <= '0;
			ref_req <= 1'b0;
		end else if (init_done) begin
			if (ref_cnt == CNT_W'(REFRESH_CYCLES - 1))
				ref_req <= 1'b1;                    // held until the FSM serves it
			else
				ref_cnt <= ref_cnt + 1'b1;
		end
	end

endmodule

// ==== hdl/sdram_ctrl_fsm.sv ====
`timescale 1ns/1ps

module sdram_ctrl_fsm #(
	parameter int CAS_LAT   = 3,
	parameter int BURST_LEN = 4
) (
	input  logic                        S_CLK,
	input  logic                        RST_N,
	input  logic                        init_done,
	input  logic [3:0]                  init_cmd,
	input  sdram_pkg::sdram_a_u         init_a,
	input  logic                        write_req,
	input  logic                        read_req,
	input  sdram_pkg::user_addr_t       addr,
	input  logic                        ref_req,
	output logic                        ref_ack,
	output logic                        wr_beat,
	output logic                        rd_cmd,
	output logic                        write_ack,
	output logic                        read_ack,
	output logic                        wr_data_req,
	output logic [3:0]                  cmd,
	output logic [sdram_pkg::BA_W-1:0]  sdram_ba,
	output logic [sdram_pkg::ROW_W-1:0] sdram_addr
);
	import sdram_pkg::*;

	localparam logic [2:0] ST_IDLE     = 3'd0;
	localparam logic [2:0] ST_REFRESH  = 3'd1;
	localparam logic [2:0] ST_ACTIVATE = 3'd2;
	localparam logic [2:0] ST_RCD      = 3'd3;
	localparam logic [2:0] ST_WRITE    = 3'd4;
	localparam logic [2:0] ST_READ     = 3'd5;
	localparam logic [2:0] ST_PRE      = 3'd6;

	localparam int CNT_W = 4;
	localparam int RD_W  = $clog2(CAS_LAT + BURST_LEN + 1);
	localparam int BL_W  = $clog2(BURST_LEN + 1);

	logic [2:0]       state;
	logic [CNT_W-1:0] cnt;                  // shared gap counter
	logic             is_wr;
	user_addr_t       addr_q;
	sdram_a_u         row_a;
	sdram_a_u         col_a;
	logic [RD_W-1:0]  rd_cnt;
	logic [BL_W-1:0]  req_left;
	logic             user_ok;
	logic             accept;
	logic             wr_req_start;

	always_comb begin
		row_a         = '0;
		row_a.row     = addr_q[COL_W +: ROW_W];
		col_a         = '0;
		col_a.cas.ap  = 1'b1;               // close the row after every burst
		col_a.cas.col = addr_q[COL_W-1:0];
	end

	// no new user burst until the previous ack has gone and read data has drained
	assign user_ok = !write_ack && !read_ack && (rd_cnt == '0);
	assign accept  = init_done && (state == ST_IDLE) && !ref_req && user_ok
		&& (write_req || read_req);
	// first strobe two cycles before WRITE, staging register adds one
	assign wr_req_start = is_wr && (((state == ST_ACTIVATE) && (T_RCD == 2))
		|| ((state == ST_RCD) && (cnt == CNT_W'(2))));

	always_ff @(posedge S_CLK) begin
		if (accept)
			addr_q <= addr;
	end

	always_ff @(posedge S_CLK or negedge RST_N) begin
		if (!RST_N) begin
			state      <= ST_IDLE;
			cnt        <= '0;
			is_wr      <= 1'b0;
			cmd        <= CMD_NOP;
			sdram_ba   <= '0;
			sdram_addr <= '0;
			ref_ack    <= 1'b0;
			wr_beat    <= 1'b0;
			rd_cmd     <= 1'b0;
			write_ack  <= 1'b0;
		end else if (!init_done) begin
			cmd        <= init_cmd;             // init sequencer owns the bus
			sdram_addr <= init_a;
		end else begin
			cmd       <= CMD_NOP;
			ref_ack   <= 1'b0;
			rd_cmd    <= 1'b0;
			write_ack <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (ref_req) begin
						cmd     <= CMD_REFRESH;
						ref_ack <= 1'b1;
						cnt     <= CNT_W'(T_RFC - 1);
						state   <= ST_REFRESH;
					end else if (accept) begin
						is_wr <= write_req;         // write wins over read
						state <= ST_ACTIVATE;
					end
				end
				ST_REFRESH: begin
					if (cnt == '0)
						state <= ST_IDLE;
					else
						cnt <= cnt - 1'b1;
				end
				ST_ACTIVATE: begin
					cmd        <= CMD_ACTIVE;
					sdram_ba   <= addr_q[COL_W+ROW_W +: BA_W];
					sdram_addr <= row_a;
					// read spends one cycle in ST_READ
					cnt        <= is_wr ? CNT_W'(T_RCD - 1) : CNT_W'(T_RCD - 2);
					state      <= ST_RCD;
				end
				ST_RCD: begin
					if (cnt != '0) begin
						cnt <= cnt - 1'b1;
					end else if (is_wr) begin
						cmd        <= CMD_WRITE;
						sdram_addr <= col_a;
						wr_beat    <= 1'b1;         // first beat rides with WRITE
						cnt        <= CNT_W'(BURST_LEN - 1);
						state      <= ST_WRITE;
					end else begin
						state <= ST_READ;
					end
				end
				ST_WRITE: begin
					if (cnt == '0) begin
						wr_beat <= 1'b0;
						cnt     <= CNT_W'(T_WR + T_RP);
						state   <= ST_PRE;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				ST_READ: begin
					cmd        <= CMD_READ;
					sdram_addr <= col_a;
					rd_cmd     <= 1'b1;
					cnt        <= CNT_W'(BURST_LEN + T_RP - 1);  // burst then auto precharge
					state      <= ST_PRE;
				end
				ST_PRE: begin
					if (cnt == '0) begin
						write_ack <= is_wr;         // reads ack from rd_cnt
						state     <= ST_IDLE;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// read_ack lines up with the last captured beat
	always_ff @(posedge S_CLK or negedge RST_N) begin
		if (!RST_N) begin
			rd_cnt   <= '0;
			read_ack <= 1'b0;
		end else begin
			read_ack <= (rd_cnt == RD_W'(1));
			if (init_done && (state == ST_READ))
				rd_cnt <= RD_W'(CAS_LAT + BURST_LEN);
			else if (rd_cnt != '0)
				rd_cnt <= rd_cnt - 1'b1;
		end
	end

	always_ff @(posedge S_CLK or negedge RST_N) begin
		if (!RST_N) begin
			req_left    <= '0;
			wr_data_req <= 1'b0;
		end else begin
			wr_data_req <= wr_req_start || (req_left != '0);
			if (wr_req_start)
				req_left <= BL_W'(BURST_LEN - 1);
			else if (req_left != '0)
				req_left <= req_left - 1'b1;
		end
	end

endmodule

// ==== hdl/sdram_data_path.sv ====
`timescale 1ns/1ps

module sdram_data_path #(
	parameter int CAS_LAT   = 3,
	parameter int BURST_LEN = 4
) (
	input  logic                       S_CLK,
	input  logic                       RST_N,
	input  sdram_pkg::word_t           wr_data,
	input  logic                       wr_beat,
	input  logic                       rd_cmd,
	inout  wire [sdram_pkg::DQ_W-1:0]  sdram_dq,
	output sdram_pkg::word_t           rd_data,
	output logic                       rd_valid
);
	import sdram_pkg::*;

	localparam int BL_W = $clog2(BURST_LEN + 1);

	word_t              wr_q;
	logic [CAS_LAT-1:0] rd_pipe;            // READ issue delayed by CAS latency
	logic [BL_W-1:0]    beat_left;
	logic               cap_en;

	always_ff @(posedge S_CLK) begin
		wr_q <= wr_data;                    // word asked for last cycle
	end

	assign sdram_dq = wr_beat ? wr_q : 'z;

	assign cap_en = rd_pipe[CAS_LAT-1] || (beat_left != '0);

	always_ff @(posedge S_CLK or negedge RST_N) begin
		if (!RST_N) begin
			rd_pipe   <= '0;
			beat_left <= '0;
			rd_valid  <= 1'b0;
		end else begin
			rd_pipe  <= {rd_pipe[CAS_LAT-2:0], rd_cmd};
			rd_valid <= cap_en;
			if (rd_pipe[CAS_LAT-1])
				beat_left <= BL_W'(BURST_LEN - 1);  // first beat is on dq now
			else if (beat_left != '0)
				beat_left <= beat_left - 1'b1;
		end
	end

	always_ff @(posedge S_CLK) begin
		if (cap_en)
			rd_data <= sdram_dq;
	end

endmodule

// ==== hdl/sdram_top.sv ====
`timescale 1ns/1ps

module sdram_top #(
	parameter int CAS_LAT          = 3,
	parameter int BURST_LEN        = 4,
	parameter int REFRESH_CYCLES   = 780,
	parameter int INIT_WAIT_CYCLES = 10000
) (
	input  logic                        S_CLK,
	input  logic                        RST_N,
	input  logic                        write_req,
	input  logic                        read_req,
	input  sdram_pkg::user_addr_t       addr,
	input  sdram_pkg::word_t            wr_data,
	output logic                        wr_data_req,
	output logic                        write_ack,
	output sdram_pkg::word_t            rd_data,
	output logic                        rd_valid,
	output logic                        read_ack,
	output logic                        init_done,
	output logic                        sdram_clk,
	output logic                        sdram_cke,
	output logic                        sdram_cs_n,
	output logic                        sdram_ras_n,
	output logic                        sdram_cas_n,
	output logic                        sdram_we_n,
	output logic [sdram_pkg::BA_W-1:0]  sdram_ba,
	output logic [sdram_pkg::ROW_W-1:0] sdram_addr,
	inout  wire  [sdram_pkg::DQ_W-1:0]  sdram_dq,
	output logic [1:0]                  sdram_dqm
);
	import sdram_pkg::*;

	logic [3:0] init_cmd;
	sdram_a_u   init_a;
	logic       ref_req;
	logic       ref_ack;
	logic       wr_beat;
	logic       rd_cmd;
	logic [3:0] cmd;

	assign sdram_clk = S_CLK;
	assign sdram_cke = 1'b1;                // no power-down
	assign sdram_dqm = 2'b00;               // no write masking
	assign {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} = cmd;

	sdram_init #(
		.CAS_LAT         (CAS_LAT),
		.BURST_LEN       (BURST_LEN),
		.INIT_WAIT_CYCLES(INIT_WAIT_CYCLES)
	) u_init (
		.S_CLK    (S_CLK),
		.RST_N    (RST_N),
		.init_cmd (init_cmd),
		.init_a   (init_a),
		.init_done(init_done)
	);

	sdram_refresh_timer #(
		.REFRESH_CYCLES(REFRESH_CYCLES)
	) u_refresh_timer (
		.S_CLK    (S_CLK),
		.RST_N    (RST_N),
		.init_done(init_done),
		.ref_ack  (ref_ack),
		.ref_req  (ref_req)
	);

	sdram_ctrl_fsm #(
		.CAS_LAT  (CAS_LAT),
		.BURST_LEN(BURST_LEN)
	) u_ctrl_fsm (
		.S_CLK      (S_CLK),
		.RST_N      (RST_N),
		.init_done  (init_done),
		.init_cmd   (init_cmd),
		.init_a     (init_a),
		.write_req  (write_req),
		.read_req   (read_req),
		.addr       (addr),
		.ref_req    (ref_req),
		.ref_ack    (ref_ack),
		.wr_beat    (wr_beat),
		.rd_cmd     (rd_cmd),
		.write_ack  (write_ack),
		.read_ack   (read_ack),
		.wr_data_req(wr_data_req),
		.cmd        (cmd),
		.sdram_ba   (sdram_ba),
		.sdram_addr (sdram_addr)
	);

	sdram_data_path #(
		.CAS_LAT  (CAS_LAT),
		.BURST_LEN(BURST_LEN)
	) u_data_path (
		.S_CLK   (S_CLK),
		.RST_N   (RST_N),
		.wr_data (wr_data),
		.wr_beat (wr_beat),
		.rd_cmd  (rd_cmd),
		.sdram_dq(sdram_dq),
		.rd_data (rd_data),
		.rd_valid(rd_valid)
	);

endmodule

// ==== tb/sdram_chip_model.sv ====
`timescale 1ns/1ps

module sdram_chip_model #(
	parameter int CAS_LAT   = 3,
	parameter int BURST_LEN = 4
) (
	input  logic                       clk,
	input  logic                       cke,
	input  logic                       cs_n,
	input  logic                       ras_n,
	input  logic                       cas_n,
	input  logic                       we_n,
	input  logic [sdram_pkg::BA_W-1:0] ba,
	input  sdram_pkg::sdram_a_u        addr,
	inout  wire  [sdram_pkg::DQ_W-1:0] dq,
	input  logic [1:0]                 dqm
);
	import sdram_pkg::*;

	word_t              mem [0:(1<<(BA_W+ROW_W+COL_W))-1];  // bank, row, column
	logic [ROW_W-1:0]   open_row [4];
	logic [3:0]         row_open = '0;
	logic [3:0]         cmd;
	logic [CAS_LAT-1:0] rd_sr = '0;     // READ seen n+1 edges ago
	user_addr_t         la;
	user_addr_t         rd_q;
	user_addr_t         rd_start;
	user_addr_t         wr_a;
	int                 rd_left = 0;
	int                 rd_beat = 0;
	int                 wr_left = 0;
	int                 wr_beat = 0;

	// sequential burst, wraps inside the burst-length block
	function automatic user_addr_t burst_addr(input user_addr_t base, input int beat);
		user_addr_t mask;
		mask = user_addr_t'(BURST_LEN - 1);
		return (base & ~mask) | ((base + user_addr_t'(beat)) & mask);
	endfunction

	assign cmd = {cs_n, ras_n, cas_n, we_n};
	assign dq  = (rd_left != 0) ? mem[burst_addr(rd_start, rd_beat)] : 'z;

	always @(posedge clk) begin
		if (cke) begin
			// a closed bank gives an unknown row, so bad data shows up on read-back
			la = {ba, row_open[ba] ? open_row[ba] : {ROW_W{1'bx}}, addr.cas.col};
			rd_sr <= {rd_sr[CAS_LAT-2:0], cmd == CMD_READ};
			if (rd_sr[CAS_LAT-2]) begin
				rd_start <= rd_q;               // valid before edge CAS_LAT after READ
				rd_beat  <= 0;
				rd_left  <= BURST_LEN;
			end else if (rd_left != 0) begin
				rd_beat <= rd_beat + 1;
				rd_left <= rd_left - 1;
			end
			if (wr_left != 0) begin
				mem[burst_addr(wr_a, wr_beat)] <= dq;
				wr_beat <= wr_beat + 1;
				wr_left <= wr_left - 1;
			end
			case (cmd)
				CMD_ACTIVE: begin
					open_row[ba] <= addr.row;
					row_open[ba] <= 1'b1;
				end
				CMD_PRECHARGE: begin
					if (addr.cas.ap)
						row_open <= '0;
					else
						row_open[ba] <= 1'b0;
				end
				CMD_WRITE: begin
					mem[la] <= dq;              // first beat comes with the command
					wr_a    <= la;
					wr_beat <= 1;
					wr_left <= BURST_LEN - 1;
					if (addr.cas.ap)
						row_open[ba] <= 1'b0;
				end
				CMD_READ: begin
					rd_q <= la;
					if (addr.cas.ap)
						row_open[ba] <= 1'b0;
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== tb/sdram_tb_assert.sv ====
`timescale 1ns/1ps

module sdram_tb_assert (
	input logic       S_CLK,
	input logic       RST_N,
	input logic       init_done,
	input logic [3:0] cmd,
	input logic       write_ack,
	input logic       read_ack
);
	import sdram_pkg::*;

	logic is_rw;
	logic is_init_cmd;

	assign is_rw       = (cmd == CMD_READ) || (cmd == CMD_WRITE);
	assign is_init_cmd = (cmd == CMD_NOP) || (cmd == CMD_PRECHARGE)
		|| (cmd == CMD_REFRESH) || (cmd == CMD_LOAD_MODE);

	a_ack_excl: assert property (@(posedge S_CLK) disable iff (!RST_N)
		!(write_ack && read_ack))
		else $error("write_ack and read_ack high together");

	// every cycle inside tRCD after ACTIVE
	genvar k;
	generate
		for (k = 1; k < T_RCD; k++) begin : g_rcd
			a_rcd: assert property (@(posedge S_CLK) disable iff (!RST_N)
				is_rw |-> ($past(cmd, k) != CMD_ACTIVE))
				else $error("READ or WRITE %0d cycles after ACTIVE", k);
		end
	endgenerate

	a_init_cmds: assert property (@(posedge S_CLK) disable iff (!RST_N)
		!init_done |-> is_init_cmd)
		else $error("user command before init_done");

endmodule

// ==== tb/sdram_tb.sv ====
`timescale 1ns/1ps

module sdram_tb;
	import sdram_pkg::*;

	localparam int CAS_LAT          = 3;
	localparam int BURST_LEN        = 4;
	localparam int REFRESH_CYCLES   = 120;
	localparam int INIT_WAIT_CYCLES = 200;
	localparam int N_ENTRIES        = 8;
	localparam int BURST_TIME       = 40;     // upper bound for one burst with precharge
	localparam int TIMEOUT          = INIT_WAIT_CYCLES + N_ENTRIES * BURST_TIME + 500;

	logic                S_CLK;
	logic                RST_N;
	logic                write_req;
	logic                read_req;
	user_addr_t          addr;
	word_t               wr_data;
	logic                wr_data_req;
	logic                write_ack;
	word_t               rd_data;
	logic                rd_valid;
	logic                read_ack;
	logic                init_done;
	logic                sdram_clk;
	logic                sdram_cke;
	logic                sdram_cs_n;
	logic                sdram_ras_n;
	logic                sdram_cas_n;
	logic                sdram_we_n;
	logic [BA_W-1:0]     sdram_ba;
	logic [ROW_W-1:0]    sdram_addr;
	wire  [DQ_W-1:0]     sdram_dq;
	logic [1:0]          sdram_dqm;

	// stimulus table: write flag, address, write entry whose data a read returns
	logic       tbl_wr   [N_ENTRIES];
	user_addr_t tbl_addr [N_ENTRIES];
	int         tbl_src  [N_ENTRIES];
	word_t      exp_words[N_ENTRIES][BURST_LEN];

	logic [3:0]  pin_cmd;
	logic [31:0] lcg_state;
	sdram_a_u    mode_a;
	sdram_a_u    exp_mode;
	logic        mode_seen      = 1'b0;
	int          cycle_cnt      = 0;
	int          cur            = 0;
	int          wr_base        = 0;
	int          rd_base        = 0;
	int          wr_req_total   = 0;
	int          rd_valid_total = 0;
	int          wack_total     = 0;
	int          rack_total     = 0;
	int          ref_gap        = 0;
	int          ref_after_init = 0;
	int          since_act      = 1000;

	assign pin_cmd = {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n};

	sdram_top #(
		.CAS_LAT         (CAS_LAT),
		.BURST_LEN       (BURST_LEN),
		.REFRESH_CYCLES  (REFRESH_CYCLES),
		.INIT_WAIT_CYCLES(INIT_WAIT_CYCLES)
	) u_dut (.*);

	sdram_chip_model #(
		.CAS_LAT  (CAS_LAT),
		.BURST_LEN(BURST_LEN)
	) u_chip (
		.clk  (sdram_clk),
		.cke  (sdram_cke),
		.cs_n (sdram_cs_n),
		.ras_n(sdram_ras_n),
		.cas_n(sdram_cas_n),
		.we_n (sdram_we_n),
		.ba   (sdram_ba),
		.addr (sdram_addr),
		.dq   (sdram_dq),
		.dqm  (sdram_dqm)
	);

	bind sdram_ctrl_fsm sdram_tb_assert u_assert (
		.S_CLK    (S_CLK),
		.RST_N    (RST_N),
		.init_done(init_done),
		.cmd      (cmd),
		.write_ack(write_ack),
		.read_ack (read_ack)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic user_addr_t make_addr(input int ba, input int row, input int col);
		return {BA_W'(ba), ROW_W'(row), COL_W'(col)};
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp)
			fail_run($sformatf("FAILED at %0t: %s expected %h got %h", $time, name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			fail_run($sformatf("FAILED at %0t: %s expected %b got %b", $time, name, exp, act));
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp)
			fail_run($sformatf("FAILED at %0t: %s expected %0d got %0d", $time, name, exp, act));
	endtask

	task automatic check_mode(input string name, input sdram_a_u exp, input sdram_a_u act);
		if (act !== exp)
			fail_run($sformatf("FAILED at %0t: %s expected %h got %h", $time, name, exp, act));
	endtask

	task automatic set_entry(input int i, input logic wr, input user_addr_t a, input int src);
		tbl_wr[i]   = wr;
		tbl_addr[i] = a;
		tbl_src[i]  = src;
	endtask

	task automatic load_table();
		set_entry(0, 1'b1, make_addr(0, 12'h010, 8'h00), 0);
		set_entry(1, 1'b1, make_addr(1, 12'h123, 252), 1);     // last four columns of the row
		set_entry(2, 1'b1, make_addr(2, 12'habc, 8'h40), 2);
		set_entry(3, 1'b1, make_addr(3, 12'hfff, 8'h00), 3);   // same column as entry 0
		set_entry(4, 1'b0, tbl_addr[2], 2);
		set_entry(5, 1'b0, tbl_addr[0], 0);
		set_entry(6, 1'b0, tbl_addr[3], 3);
		set_entry(7, 1'b0, tbl_addr[1], 1);
	endtask

	task automatic fill_scoreboard();
		lcg_state = 32'd7;
		for (int i = 0; i < N_ENTRIES; i++) begin
			for (int b = 0; b < BURST_LEN; b++) begin
				if (tbl_wr[i]) begin
					lcg_state       = lcg_next(lcg_state);
					exp_words[i][b] = lcg_state[30:15];
				end else begin
					exp_words[i][b] = exp_words[tbl_src[i]][b];
				end
			end
		end
	endtask

	// hold the request until its own ack, then check the beat and ack counts
	task automatic run_entry(input int i);
		int wack_start;
		int rack_start;
		@(posedge S_CLK);
		cur        = i;
		wr_base    = wr_req_total;
		rd_base    = rd_valid_total;
		wack_start = wack_total;
		rack_start = rack_total;
		addr <= tbl_addr[i];
		if (tbl_wr[i])
			write_req <= 1'b1;
		else
			read_req <= 1'b1;
		do
			@(posedge S_CLK);
		while (!(tbl_wr[i] ? write_ack : read_ack));
		write_req <= 1'b0;
		read_req  <= 1'b0;
		@(posedge S_CLK);                       // last beat is counted at the ack edge
		if (tbl_wr[i])
			check_count("wr_data_req pulses", BURST_LEN, wr_req_total - wr_base);
		else
			check_count("rd_valid beats", BURST_LEN, rd_valid_total - rd_base);
		check_count("write_ack pulses", tbl_wr[i] ? 1 : 0, wack_total - wack_start);
		check_count("read_ack pulses", tbl_wr[i] ? 0 : 1, rack_total - rack_start);
		repeat (10) @(posedge S_CLK);           // user idles, refresh timer keeps running
	endtask

	initial begin
		S_CLK = 1'b0;
		forever #10 S_CLK = ~S_CLK;
	end

	initial begin
		RST_N     = 1'b0;
		write_req = 1'b0;
		read_req  = 1'b0;
		addr      = '0;
		wr_data   = '0;
		load_table();
		fill_scoreboard();
		exp_mode                = '0;
		exp_mode.mode.cas_lat   = 3'd3;
		exp_mode.mode.burst_len = 3'd2;         // code for four beats
		repeat (2) @(posedge S_CLK);
		RST_N <= 1'b1;
		run_entry(0);                           // requested during init, served after it
		check_flag("load_mode_seen", 1'b1, mode_seen);
		check_mode("sdram_addr (mode word)", exp_mode, mode_a);
		for (int i = 1; i < N_ENTRIES; i++)
			run_entry(i);
		check_flag("refresh_after_init", 1'b1, ref_after_init > 0);
		$display("Finished with no errors");
		$finish;
	end

	// pin monitor, write data source and read data check
	always @(posedge S_CLK) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT)
			fail_run($sformatf("timeout after %0d cycles, a request was never acked", cycle_cnt));
		if (!init_done && (write_ack || read_ack))
			fail_run("a user request was acked before init_done");
		if (write_ack && read_ack)
			fail_run("write_ack and read_ack were high in the same cycle");
		if (!init_done && (pin_cmd == CMD_ACTIVE || pin_cmd == CMD_READ
			|| pin_cmd == CMD_WRITE))
			fail_run("a user command reached the pins before init_done");
		check_flag("sdram_cke", 1'b1, sdram_cke);
		check_count("sdram_dqm", 0, sdram_dqm);
		if (pin_cmd == CMD_LOAD_MODE) begin
			mode_seen = 1'b1;
			mode_a    = sdram_addr;
		end
		if (pin_cmd == CMD_REFRESH) begin
			ref_gap = 0;
			if (init_done)
				ref_after_init++;
		end else begin
			ref_gap++;
			if (init_done && ref_gap > REFRESH_CYCLES + BURST_TIME)
				fail_run("no REFRESH within one refresh interval plus one burst");
		end
		if ((pin_cmd == CMD_READ || pin_cmd == CMD_WRITE) && since_act + 1 < T_RCD)
			fail_run("READ or WRITE came too soon after ACTIVE");
		since_act = (pin_cmd == CMD_ACTIVE) ? 0 : since_act + 1;
		if (wr_data_req) begin
			if (wr_req_total - wr_base < BURST_LEN)
				wr_data <= exp_words[cur][wr_req_total - wr_base];  // next word
			wr_req_total++;
		end
		if (rd_valid) begin
			if (rd_valid_total - rd_base < BURST_LEN)
				check_word($sformatf("rd_data beat %0d of entry %0d", rd_valid_total - rd_base,
					cur), exp_words[cur][rd_valid_total - rd_base], rd_data);
			rd_valid_total++;
		end
		wack_total += write_ack;
		rack_total += read_ack;
	end

endmodule

// ==== src.f ====
hdl/sdram_pkg.sv
hdl/sdram_init.sv
hdl/sdram_refresh_timer.sv
hdl/sdram_ctrl_fsm.sv
hdl/sdram_data_path.sv
hdl/sdram_top.sv
tb/sdram_chip_model.sv
tb/sdram_tb_assert.sv
tb/sdram_tb.sv

// ==== Bender.yml ====
package:
  name: sdram_ctrl

sources:
  - hdl/sdram_pkg.sv
  - hdl/sdram_init.sv
  - hdl/sdram_refresh_timer.sv
  - hdl/sdram_ctrl_fsm.sv
  - hdl/sdram_data_path.sv
  - hdl/sdram_top.sv
  - target: test
    files:
      - tb/sdram_chip_model.sv
      - tb/sdram_tb_assert.sv
      - tb/sdram_tb.sv
